/* hw/lsu_cfg_pkg.sv */
package lsu_cfg_pkg;

   // physical byte address
   localparam int ADDR_W = 32;

   // widest access is one 8-byte word
   localparam int DATA_W = 64;

   // data cache line size in bytes as a power of two
   localparam int LINE_BYTES_DEF = 16;

   // byte counts run 0 to 8
   localparam int CNT_W = 4;

endpackage

/* hw/lsu_types_pkg.sv */
package lsu_types_pkg;

   typedef logic [lsu_cfg_pkg::DATA_W-1:0] data_t;

   // access from a pipeline stage
   // size_code 0..3 selects 1, 2, 4 or 8 bytes
   typedef struct packed {
      logic [lsu_cfg_pkg::ADDR_W-1:0] addr;
      logic [1:0]                     size_code;
   } mem_req_t;

   // result of the line crossing check
   // addr2 and bytes2 only mean something when split is set
   typedef struct packed {
      logic                           split;
      logic [lsu_cfg_pkg::ADDR_W-1:0] addr1;
      logic [lsu_cfg_pkg::ADDR_W-1:0] addr2;
      logic [lsu_cfg_pkg::CNT_W-1:0]  bytes1;
      logic [lsu_cfg_pkg::CNT_W-1:0]  bytes2;
   } split_t;

   // one data cache access of 102 bits
   typedef struct packed {
      logic                           en;
      logic                           write;
      logic [lsu_cfg_pkg::ADDR_W-1:0] addr;
      logic [lsu_cfg_pkg::CNT_W-1:0]  bytes;
      data_t                          wdata;
   } cache_req_t;

   // first part of every access is served from idle
   typedef enum logic [1:0] {
      SEQ_IDLE      = 2'd0,
      SEQ_RD_SECOND = 2'd1,
      SEQ_WR_SECOND = 2'd2
   } seq_state_e;

endpackage

/* hw/line_split.sv */
module line_split #(
   parameter int LINE_BYTES = lsu_cfg_pkg::LINE_BYTES_DEF
) (
   input  lsu_types_pkg::mem_req_t req,
   output lsu_types_pkg::split_t   split_info
);
   import lsu_cfg_pkg::*;
   import lsu_types_pkg::*;

   localparam int OFF_W = $clog2(LINE_BYTES);

   logic [OFF_W-1:0]  offset;
   logic [CNT_W-1:0]  n;
   logic [OFF_W:0]    end_pos;
   logic [ADDR_W-1:0] line_base;
   logic              crosses;

   assign offset    = req.addr[OFF_W-1:0];
   assign n         = CNT_W'(1) << req.size_code;
   assign end_pos   = {1'b0, offset} + (OFF_W + 1)'(n);
   assign line_base = {req.addr[ADDR_W-1:OFF_W], {OFF_W{1'b0}}};

   // one byte past the line end is already a crossing
   assign crosses = end_pos > (OFF_W + 1)'(LINE_BYTES);

   always_comb
   begin
      split_info.split = crosses;
      split_info.addr1 = req.addr;
      // second part always starts at the next line base
      split_info.addr2 = line_base + ADDR_W'(LINE_BYTES);
      if (crosses)
      begin
         split_info.bytes1 = CNT_W'(LINE_BYTES - int'(offset));
         split_info.bytes2 = n - CNT_W'(LINE_BYTES - int'(offset));
      end
      else
      begin
         split_info.bytes1 = n;
         split_info.bytes2 = '0;
      end
   end

   // both parts together cover exactly the requested bytes
   always_comb
   begin
      if (!$isunknown(req))
      begin
         assert final ((CNT_W + 1)'(split_info.bytes1) + (CNT_W + 1)'(split_info.bytes2)
                       == (CNT_W + 1)'(n))
         else
            $error("line_split byte counts do not add up to %0d", n);
      end
   end

endmodule

/* hw/access_seq.sv */
module access_seq (
   input  logic                     clk,
   input  logic                     rst_n,
   input  logic                     rd_v,
   input  logic                     wr_v,
   input  lsu_types_pkg::split_t    rd_split,
   input  lsu_types_pkg::split_t    wr_split,
   input  logic                     cache_ready,
   output lsu_types_pkg::cache_req_t port,
   output logic                     part2,
   output logic                     cap_rd,
   output logic                     cap_wr,
   output logic                     rd_stall,
   output logic                     wr_stall
);
   import lsu_types_pkg::*;

   seq_state_e state_q;
   seq_state_e state_d;
   split_t     sel_split;
   logic       sel_wr;
   logic       sel_v;
   logic       accept;
   logic       capture;
   logic       done;

   // write wins in idle, a second part keeps its owner
   always_comb
   begin
      case (state_q)
         SEQ_RD_SECOND: sel_wr = 1'b0;
         SEQ_WR_SECOND: sel_wr = 1'b1;
         default:       sel_wr = wr_v;
      endcase
   end

   assign sel_split = sel_wr ? wr_split : rd_split;
   assign sel_v     = sel_wr ? wr_v : rd_v;
   assign part2     = (state_q != SEQ_IDLE);

   // cache took the access on this edge
   assign accept  = sel_v & cache_ready;
   assign capture = accept & ~part2 & sel_split.split;
   assign done    = accept & (part2 | ~sel_split.split);

   assign cap_rd = capture & ~sel_wr;
   assign cap_wr = capture & sel_wr;

   assign rd_stall = rd_v & ~(done & ~sel_wr);
   assign wr_stall = wr_v & ~(done & sel_wr);

   always_comb
   begin
      port.en    = rd_v | wr_v;
      port.write = sel_wr;
      port.addr  = part2 ? sel_split.addr2 : sel_split.addr1;
      port.bytes = part2 ? sel_split.bytes2 : sel_split.bytes1;
      // write data is merged in at the top level
      port.wdata = '0;
   end

   always_comb
   begin
      state_d = state_q;
      case (state_q)
         SEQ_IDLE:
         begin
            if (capture)
               state_d = sel_wr ? SEQ_WR_SECOND : SEQ_RD_SECOND;
         end
         SEQ_RD_SECOND,
         SEQ_WR_SECOND:
         begin
            if (accept)
               state_d = SEQ_IDLE;
         end
         default: state_d = SEQ_IDLE;
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (!rst_n)
         state_q <= SEQ_IDLE;
      else
         state_q <= state_d;
   end

   // a second part follows an accepted first part of a split access
   a_second_entry: assert property (@(posedge clk) disable iff (!rst_n)
      $rose(part2) |-> $past(sel_split.split && cache_ready));

   // stage only sees completion on a ready pulse
   a_rd_done_ready: assert property (@(posedge clk) disable iff (!rst_n)
      (rd_v && !rd_stall) |-> cache_ready);

   a_wr_done_ready: assert property (@(posedge clk) disable iff (!rst_n)
      (wr_v && !wr_stall) |-> cache_ready);

endmodule

/* hw/split_data_path.sv */
module split_data_path (
   input  logic                          clk,
   input  logic                          rst_n,
   input  lsu_types_pkg::data_t          cache_rdata,
   input  lsu_types_pkg::data_t          wr_data,
   input  logic [lsu_cfg_pkg::CNT_W-1:0] rd_bytes1,
   input  logic [lsu_cfg_pkg::CNT_W-1:0] wr_bytes1,
   input  logic                          part2,
   input  logic                          cap_rd,
   input  logic                          cap_wr,
   output lsu_types_pkg::data_t          rd_data,
   output lsu_types_pkg::data_t          wdata
);
   import lsu_cfg_pkg::*;
   import lsu_types_pkg::*;

   logic [CNT_W+2:0] rd_sh;
   logic [CNT_W+2:0] wr_sh;
   data_t            rd_mask;
   data_t            rd_part_q;
   data_t            wr_part_q;
   logic             wr_owner_q;
   logic             rd_second;
   logic             wr_second;

   // byte counts to bit shifts
   assign rd_sh = {rd_bytes1, 3'b000};
   assign wr_sh = {wr_bytes1, 3'b000};

   // low rd_bytes1 bytes set
   assign rd_mask = (data_t'(1) << rd_sh) - data_t'(1);

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         rd_part_q  <= '0;
         wr_part_q  <= '0;
         wr_owner_q <= 1'b0;
      end
      else
      begin
         if (cap_rd)
         begin
            rd_part_q  <= cache_rdata & rd_mask;
            wr_owner_q <= 1'b0;
         end
         if (cap_wr)
         begin
            // upper bytes move down to byte 0 of the next line
            wr_part_q  <= wr_data >> wr_sh;
            wr_owner_q <= 1'b1;
         end
      end
   end

   // which access owns the current second part
   assign rd_second = part2 & ~wr_owner_q;
   assign wr_second = part2 & wr_owner_q;

   // second line bytes land above the held first part
   assign rd_data = rd_second ? (rd_part_q | (cache_rdata << rd_sh)) : cache_rdata;

   assign wdata = wr_second ? wr_part_q : wr_data;

endmodule

/* hw/lsu_top.sv */
module lsu_top #(
   parameter int LINE_BYTES = lsu_cfg_pkg::LINE_BYTES_DEF
) (
   input  logic                      clk,
   input  logic                      rst_n,
   input  logic                      rd_v,
   input  lsu_types_pkg::mem_req_t   rd_req,
   input  logic                      wr_v,
   input  lsu_types_pkg::mem_req_t   wr_req,
   input  lsu_types_pkg::data_t      wr_data,
   input  lsu_types_pkg::data_t      cache_rdata,
   input  logic                      cache_ready,
   output lsu_types_pkg::cache_req_t cache_req,
   output logic                      rd_stall,
   output logic                      wr_stall,
   output lsu_types_pkg::data_t      rd_data
);
   import lsu_types_pkg::*;

   split_t     rd_split;
   split_t     wr_split;
   cache_req_t seq_port;
   data_t      dp_wdata;
   logic       part2;
   logic       cap_rd;
   logic       cap_wr;

   line_split #(
      .LINE_BYTES (LINE_BYTES)
   ) u_rd_split (
      .req        (rd_req),
      .split_info (rd_split)
   );

   line_split #(
      .LINE_BYTES (LINE_BYTES)
   ) u_wr_split (
      .req        (wr_req),
      .split_info (wr_split)
   );

   access_seq u_access_seq (
      .clk         (clk),
      .rst_n       (rst_n),
      .rd_v        (rd_v),
      .wr_v        (wr_v),
      .rd_split    (rd_split),
      .wr_split    (wr_split),
      .cache_ready (cache_ready),
      .port        (seq_port),
      .part2       (part2),
      .cap_rd      (cap_rd),
      .cap_wr      (cap_wr),
      .rd_stall    (rd_stall),
      .wr_stall    (wr_stall)
   );

   split_data_path u_split_data_path (
      .clk         (clk),
      .rst_n       (rst_n),
      .cache_rdata (cache_rdata),
      .wr_data     (wr_data),
      .rd_bytes1   (rd_split.bytes1),
      .wr_bytes1   (wr_split.bytes1),
      .part2       (part2),
      .cap_rd      (cap_rd),
      .cap_wr      (cap_wr),
      .rd_data     (rd_data),
      .wdata       (dp_wdata)
   );

   // control fields from the sequencer, write data from the data path
   assign cache_req = '{en:    seq_port.en,
                        write: seq_port.write,
                        addr:  seq_port.addr,
                        bytes: seq_port.bytes,
                        wdata: dp_wdata};

endmodule

/* verif/dcache_model.sv */
module dcache_model (
   input  logic                      clk,
   input  logic                      rst_n,
   input  lsu_types_pkg::cache_req_t cache_req,
   output lsu_types_pkg::data_t      cache_rdata,
   output logic                      cache_ready
);

   logic [7:0]  mem [0:511];
   logic [31:0] lat_rng;

   initial
   begin
      lat_rng = 32'hfdfd_6654;
      // same fill as the testbench shadow array
      for (int i = 0; i < 512; i++)
         mem[i] = 8'(i * 29) ^ 8'(i >> 8);
      cache_ready = 1'b0;
      cache_rdata = '0;
      forever
      begin
         @(posedge clk);
         if (rst_n && cache_req.en)
         begin
            lat_rng = tb_lsu.xorshift(lat_rng);
            // ready comes 1 to 3 cycles after en is seen
            repeat (lat_rng % 3)
               @(posedge clk);
            #1;
            for (int i = 0; i < 8; i++)
               cache_rdata[8*i +: 8] = mem[9'(cache_req.addr + i)];
            cache_ready = 1'b1;
            @(posedge clk);
            // access is taken on this edge
            tb_lsu.check_cache_req(cache_req);
            if (cache_req.write)
               for (int i = 0; i < int'(cache_req.bytes); i++)
                  mem[9'(cache_req.addr + i)] = cache_req.wdata[8*i +: 8];
            #1;
            cache_ready = 1'b0;
         end
      end
   end

endmodule

/* verif/tb_lsu.sv */
module tb_lsu;
   import lsu_cfg_pkg::*;
   import lsu_types_pkg::*;

   localparam int LINE = LINE_BYTES_DEF;
   localparam int N_ALIGNED = 8;
   localparam int N_SPLIT = 6;
   localparam int N_PAIR = 4;
   // aligned pairs, split writes with two readbacks, split reads, read and write pairs
   localparam int N_ACC = 2 * N_ALIGNED + 4 * N_SPLIT + 2 * N_PAIR;
   localparam int TIMEOUT = (N_ACC * 10 + 20) * 8;

   logic        clk, rst_n, rd_v, wr_v, cache_ready, rd_stall, wr_stall;
   logic        rd_fin, wr_fin;
   mem_req_t    rd_req, wr_req;
   data_t       wr_data, cache_rdata, rd_data;
   cache_req_t  cache_req;
   cache_req_t  exp_q [$];
   logic [7:0]  shadow [0:511];
   logic [31:0] rng;
   int          errors, checks, tests, test_base;

   lsu_top #(.LINE_BYTES(LINE)) DUT (.*);
   dcache_model u_cache (.*);

   function automatic logic [31:0] xorshift(input logic [31:0] x);
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      return x ^ (x << 5);
   endfunction

   function automatic logic [31:0] next_rand();
      rng = xorshift(rng);
      return rng;
   endfunction

   // offset that makes an access of this size run past the line end
   function automatic int cross_off(input logic [1:0] sz);
      return LINE - 1 - int'(next_rand() % ((1 << sz) - 1));
   endfunction

   // expected load result over the requested bytes only
   function automatic data_t ref_read(input logic [ADDR_W-1:0] a, input logic [1:0] sz);
      data_t r;
      r = '0;
      for (int i = 0; i < (1 << sz); i++)
         r[8*i +: 8] = shadow[9'(a + i)];
      return r;
   endfunction

   task automatic report_error(input string msg);
      errors++;
      $display("%s", msg);
   endtask

   task automatic check_cache_req(input cache_req_t got);
      cache_req_t exp;
      checks++;
      if (exp_q.size() == 0)
         report_error($sformatf("cache access to %h that no request called for", got.addr));
      else
      begin
         exp = exp_q.pop_front();
         if (!got.write)
            got.wdata = '0;
         if (got !== exp)
            report_error({$sformatf("Mismatch at %0t: cache wr %b addr %h bytes %0d wdata %h,",
               $time, got.write, got.addr, got.bytes, got.wdata),
               $sformatf(" expected wr %b addr %h bytes %0d wdata %h",
               exp.write, exp.addr, exp.bytes, exp.wdata)});
      end
   endtask

   task automatic check_rd_data(input data_t got, input data_t exp);
      checks++;
      if (got !== exp)
         report_error($sformatf("Mismatch at %0t: read data %h, expected %h", $time, got, exp));
   endtask

   // queue the cache parts given by the line split rule, then raise the request
   task automatic start_access(input logic wr, input logic [ADDR_W-1:0] a,
                               input logic [1:0] sz, input data_t d);
      cache_req_t p;
      int n;
      int b1;
      n = 1 << sz;
      b1 = (a % LINE + n > LINE) ? LINE - a % LINE : n;
      p = '{en: 1'b1, write: wr, addr: a, bytes: CNT_W'(b1), wdata: wr ? d : '0};
      exp_q.push_back(p);
      if (b1 < n)
      begin
         p.addr = a - a % LINE + LINE;
         p.bytes = CNT_W'(n - b1);
         p.wdata = p.wdata >> (8 * b1);
         exp_q.push_back(p);
      end
      if (wr)
      begin
         wr_req = '{addr: a, size_code: sz};
         wr_data = d;
         wr_v = 1'b1;
      end
      else
      begin
         rd_req = '{addr: a, size_code: sz};
         rd_v = 1'b1;
      end
   endtask

   // drop each request after the edge that completed it
   task automatic finish_all();
      while (rd_v || wr_v)
      begin
         @(posedge clk);
         #1;
         if (rd_fin)
            rd_v = 1'b0;
         if (wr_fin)
            wr_v = 1'b0;
         rd_fin = 1'b0;
         wr_fin = 1'b0;
      end
      @(posedge clk);
      #1;
   endtask

   task automatic report_test(input string name);
      if (exp_q.size() != 0)
         report_error($sformatf("%0d expected cache accesses never happened", exp_q.size()));
      exp_q.delete();
      $display("test %0d %s: %0d errors", tests, name, errors - test_base);
      tests++;
      test_base = errors;
   endtask

   // compare process for every completing access
   always @(posedge clk)
   begin
      if (rst_n)
      begin
         if ((rd_stall && !rd_v) || (wr_stall && !wr_v) || (cache_req.en && !rd_v && !wr_v))
            report_error($sformatf("stall or cache enable high with no request at %0t", $time));
         if (((rd_v && !rd_stall) || (wr_v && !wr_stall)) && !cache_ready)
            report_error($sformatf("stall dropped without a ready pulse at %0t", $time));
         if (rd_v && !rd_stall)
         begin
            check_rd_data(rd_data & ~({DATA_W{1'b1}} << (8 << rd_req.size_code)),
                          ref_read(rd_req.addr, rd_req.size_code));
            rd_fin = 1'b1;
         end
         if (wr_v && !wr_stall)
         begin
            for (int i = 0; i < (1 << wr_req.size_code); i++)
               shadow[9'(wr_req.addr + i)] = wr_data[8*i +: 8];
            wr_fin = 1'b1;
         end
      end
   end

   initial
   begin
      clk = 1'b0;
      forever
         #4 clk = ~clk;
   end

   initial
   begin
      #(TIMEOUT);
      $display("run timed out after %0d time units with accesses still open", TIMEOUT);
      $display("TB FAILED");
      $finish;
   end

   initial
   begin
      logic [ADDR_W-1:0] a;
      logic [ADDR_W-1:0] base;
      logic [1:0]        sz;
      rng = 32'hfdfd_6654;
      errors = 0;
      checks = 0;
      tests = 0;
      test_base = 0;
      rst_n = 1'b0;
      rd_v = 1'b0;
      wr_v = 1'b0;
      rd_req = '0;
      wr_req = '0;
      wr_data = '0;
      rd_fin = 1'b0;
      wr_fin = 1'b0;
      for (int i = 0; i < 512; i++)
         shadow[i] = 8'(i * 29) ^ 8'(i >> 8);
      repeat (4)
         @(posedge clk);
      #1;
      rst_n = 1'b1;
      repeat (6)
         @(posedge clk);
      #1;
      report_test("idle after reset");
      for (int t = 0; t < N_ALIGNED; t++)
      begin
         sz = 2'(next_rand());
         a = next_rand() & 32'h1ff & ~((32'd1 << sz) - 32'd1);
         start_access(1'b1, a, sz, {next_rand(), next_rand()});
         finish_all();
         start_access(1'b0, a, sz, '0);
         finish_all();
      end
      report_test("aligned reads and writes");
      for (int t = 0; t < N_SPLIT; t++)
      begin
         sz = 2'(1 + next_rand() % 3);
         base = next_rand() & 32'h1f0;
         start_access(1'b1, base + cross_off(sz), sz, {next_rand(), next_rand()});
         finish_all();
         // aligned words on both sides of the line end
         start_access(1'b0, base + 8, 2'd3, '0);
         finish_all();
         start_access(1'b0, base + LINE, 2'd3, '0);
         finish_all();
      end
      report_test("split writes");
      for (int t = 0; t < N_SPLIT; t++)
      begin
         sz = 2'(1 + next_rand() % 3);
         start_access(1'b0, (next_rand() & 32'h1f0) + cross_off(sz), sz, '0);
         finish_all();
      end
      report_test("split reads");
      for (int t = 0; t < N_PAIR; t++)
      begin
         base = next_rand() & 32'h1e0;
         sz = 2'(1 + next_rand() % 3);
         start_access(1'b1, base + cross_off(sz), sz, {next_rand(), next_rand()});
         sz = 2'(1 + next_rand() % 3);
         // read two lines further on, so no byte is shared
         start_access(1'b0, base + 2 * LINE + cross_off(sz), sz, '0);
         finish_all();
      end
      report_test("read and write together");
      $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
      if (errors == 0)
         $display("TB PASSED");
      else
         $display("TB FAILED");
      $finish;
   end

endmodule

/* tb.f */
hw/lsu_cfg_pkg.sv
hw/lsu_types_pkg.sv
hw/line_split.sv
hw/access_seq.sv
hw/split_data_path.sv
hw/lsu_top.sv
verif/dcache_model.sv
verif/tb_lsu.sv
